// File: hw/csi2_pkg.sv
package csi2_pkg;

	////////////////////////////////////////////////////////////
	// lane, byte and word widths
	////////////////////////////////////////////////////////////

	// bits per lane per mipi_clk_2 cycle
	localparam int NIBBLE_W = 4;
	localparam int BYTE_W   = 8;
	localparam int WORD_W   = 32;

	// HS sync pattern, bit 0 arrives first
	localparam logic [BYTE_W-1:0] SYNC_BYTE = 8'hB8;

	////////////////////////////////////////////////////////////
	// packet data types and line format
	////////////////////////////////////////////////////////////

	localparam logic [5:0] DT_FRAME_START = 6'h00;
	localparam logic [5:0] DT_FRAME_END   = 6'h01;
	localparam logic [5:0] DT_RAW8        = 6'h2A;

	// below this value a packet is short and has no payload
	localparam logic [5:0] SHORT_DT_LIMIT = 6'h10;

	// only one line length is accepted
	localparam int LINE_BYTES = 640;
	localparam int LINE_WORDS = LINE_BYTES / 4;

	////////////////////////////////////////////////////////////
	// header ECC and payload CRC
	////////////////////////////////////////////////////////////

	// ECC bit n is the parity of the header bits under mask n
	localparam logic [23:0] ECC_MASK0 = 24'hF12CB7;
	localparam logic [23:0] ECC_MASK1 = 24'hF2555B;
	localparam logic [23:0] ECC_MASK2 = 24'h749A6D;
	localparam logic [23:0] ECC_MASK3 = 24'hB8E38E;
	localparam logic [23:0] ECC_MASK4 = 24'hDF03F0;
	localparam logic [23:0] ECC_MASK5 = 24'hEFFC00;

	// entry i is the syndrome of a flip in header bit i
	localparam logic [7:0] ECC_SYNDROME_TABLE [24] = '{
		8'h07, 8'h0B, 8'h0D, 8'h0E, 8'h13, 8'h15, 8'h16, 8'h19,
		8'h1A, 8'h1C, 8'h23, 8'h25, 8'h26, 8'h29, 8'h2A, 8'h2C,
		8'h31, 8'h32, 8'h34, 8'h38, 8'h1F, 8'h2F, 8'h37, 8'h3B
	};

	// reflected form of x^16 + x^12 + x^5 + 1
	localparam logic [15:0] CRC_POLY = 16'h8408;
	localparam logic [15:0] CRC_INIT = 16'hFFFF;

	////////////////////////////////////////////////////////////
	// payload buffer
	////////////////////////////////////////////////////////////

	localparam int FIFO_DEPTH = 8;
	localparam int TAG_W      = 2;

	// frame start carries a zero data field
	localparam logic [TAG_W-1:0] TAG_FS   = 2'd0;
	localparam logic [TAG_W-1:0] TAG_DATA = 2'd1;
	// crc entry holds the packet CRC in bits 15:0
	localparam logic [TAG_W-1:0] TAG_CRC  = 2'd2;

endpackage

// File: hw/hs_lane_aligner.sv
module hs_lane_aligner (
	input  logic                          mipi_clk_2,
	input  logic                          reset,
	input  logic                          rx_active_i,
	input  logic [csi2_pkg::NIBBLE_W-1:0] lane_bits_i,
	output logic [csi2_pkg::BYTE_W-1:0]   byte_o,
	output logic                          byte_valid_o
);

	// three nibbles of history, newest nibble in the top bits
	logic [3*csi2_pkg::NIBBLE_W-1:0] hist;
	logic                            locked;
	logic                            uneven;
	logic                            half;

	logic [csi2_pkg::BYTE_W-1:0]     win_even;
	logic [csi2_pkg::BYTE_W-1:0]     win_uneven;
	logic                            hit_even;
	logic                            hit_uneven;

	// even phase, byte fills the two newest nibbles
	assign win_even = hist[3*csi2_pkg::NIBBLE_W-1 -: csi2_pkg::BYTE_W];

	// uneven phase, byte ends two bits into the newest nibble
	assign win_uneven = hist[3*csi2_pkg::NIBBLE_W-3 -: csi2_pkg::BYTE_W];

	assign hit_even   = !locked && (win_even == csi2_pkg::SYNC_BYTE);
	assign hit_uneven = !locked && (win_uneven == csi2_pkg::SYNC_BYTE);

	////////////////////////////////////////////////////////////
	// sync search and phase lock
	////////////////////////////////////////////////////////////

	// the cycle in which hist first holds the whole sync byte is the hit;
	// half comes up two cycles later, when the first data byte is in place
	always_ff @(posedge mipi_clk_2) begin
		if (reset || !rx_active_i) begin
			hist   <= '0;
			locked <= 1'b0;
			uneven <= 1'b0;
			half   <= 1'b0;
		end else begin
			hist <= {lane_bits_i, hist[3*csi2_pkg::NIBBLE_W-1:csi2_pkg::NIBBLE_W]};
			if (locked) begin
				half <= !half;
			end else if (hit_even || hit_uneven) begin
				locked <= 1'b1;
				// even wins if both windows match
				uneven <= !hit_even;
				half   <= 1'b0;
			end
		end
	end

	////////////////////////////////////////////////////////////
	// byte output
	////////////////////////////////////////////////////////////

	// a full byte sits in the window every second cycle
	assign byte_o       = uneven ? win_uneven : win_even;
	assign byte_valid_o = locked && half;

endmodule

// File: hw/csi_packet_parser.sv
module csi_packet_parser (
	input  logic                          mipi_clk_2,
	input  logic                          reset,
	input  logic                          rx_active_i,
	input  logic [csi2_pkg::NIBBLE_W-1:0] lane0_bits_i,
	input  logic [csi2_pkg::NIBBLE_W-1:0] lane1_bits_i,
	output logic                          push_o,
	output logic [csi2_pkg::WORD_W-1:0]   push_data_o,
	output logic [csi2_pkg::TAG_W-1:0]    push_tag_o
);

	typedef enum logic [1:0] {
		S_HDR,
		S_PAYLOAD,
		S_CRC,
		S_IGNORE
	} state_t;

	state_t                              state;
	logic [csi2_pkg::BYTE_W-1:0]         lane0_byte;
	logic [csi2_pkg::BYTE_W-1:0]         lane1_byte;
	logic                                lane0_valid;
	logic                                pair_sel;
	logic [2*csi2_pkg::BYTE_W-1:0]       low_half;
	logic [csi2_pkg::WORD_W-1:0]         word;
	logic                                word_done;
	logic [$clog2(csi2_pkg::LINE_WORDS)-1:0] word_cnt;

	logic [5:0]                          ecc_calc;
	logic [7:0]                          syndrome;
	logic [23:0]                         flip;
	logic [23:0]                         hdr_fix;
	logic                                hdr_ok;
	logic [5:0]                          hdr_dt;
	logic [15:0]                         hdr_wc;
	logic                                is_long;
	logic                                accept_line;

	// lane 1 runs in step with lane 0, so only lane 0's strobe is used
	hs_lane_aligner u_lane0 (
		.mipi_clk_2   (mipi_clk_2),
		.reset        (reset),
		.rx_active_i  (rx_active_i),
		.lane_bits_i  (lane0_bits_i),
		.byte_o       (lane0_byte),
		.byte_valid_o (lane0_valid)
	);

	hs_lane_aligner u_lane1 (
		.mipi_clk_2   (mipi_clk_2),
		.reset        (reset),
		.rx_active_i  (rx_active_i),
		.lane_bits_i  (lane1_bits_i),
		.byte_o       (lane1_byte),
		.byte_valid_o ()
	);

	// little-endian word with the even bytes from lane 0
	assign word      = {lane1_byte, lane0_byte, low_half};
	assign word_done = lane0_valid && pair_sel;

	////////////////////////////////////////////////////////////
	// header ECC check and single-bit correction
	////////////////////////////////////////////////////////////

	assign ecc_calc[0] = ^(word[23:0] & csi2_pkg::ECC_MASK0);
	assign ecc_calc[1] = ^(word[23:0] & csi2_pkg::ECC_MASK1);
	assign ecc_calc[2] = ^(word[23:0] & csi2_pkg::ECC_MASK2);
	assign ecc_calc[3] = ^(word[23:0] & csi2_pkg::ECC_MASK3);
	assign ecc_calc[4] = ^(word[23:0] & csi2_pkg::ECC_MASK4);
	assign ecc_calc[5] = ^(word[23:0] & csi2_pkg::ECC_MASK5);

	// ecc bits 7:6 are always sent as zero
	assign syndrome = {2'b00, ecc_calc} ^ word[31:24];

	always_comb begin
		flip = '0;
		for (int i = 0; i < 24; i++) begin
			if (syndrome == csi2_pkg::ECC_SYNDROME_TABLE[i]) begin
				flip[i] = 1'b1;
			end
		end
	end

	assign hdr_fix = word[23:0] ^ flip;
	assign hdr_ok  = (syndrome == 8'h00) || (flip != '0);
	assign hdr_dt  = hdr_fix[5:0];
	assign hdr_wc  = hdr_fix[23:8];

	assign is_long     = hdr_dt >= csi2_pkg::SHORT_DT_LIMIT;
	assign accept_line = is_long && (hdr_dt == csi2_pkg::DT_RAW8) &&
		(hdr_wc == 16'(csi2_pkg::LINE_BYTES));

	////////////////////////////////////////////////////////////
	// packet FSM
	////////////////////////////////////////////////////////////

	always_ff @(posedge mipi_clk_2) begin
		if (reset || !rx_active_i) begin
			state    <= S_HDR;
			pair_sel <= 1'b0;
			word_cnt <= '0;
			push_o   <= 1'b0;
		end else begin
			push_o <= 1'b0;
			if (lane0_valid) begin
				pair_sel <= !pair_sel;
			end
			case (state)
				S_HDR: begin
					if (word_done) begin
						if (!hdr_ok) begin
							state <= S_IGNORE;
						end else begin
							case (hdr_dt)
								csi2_pkg::DT_FRAME_START: begin
									push_o <= 1'b1;
									state  <= S_IGNORE;
								end
								// nothing downstream acts on frame end
								csi2_pkg::DT_FRAME_END: state <= S_IGNORE;
								default: state <= accept_line ? S_PAYLOAD : S_IGNORE;
							endcase
						end
					end
				end
				S_PAYLOAD: begin
					if (word_done) begin
						push_o <= 1'b1;
						if (word_cnt == ($bits(word_cnt))'(csi2_pkg::LINE_WORDS - 1)) begin
							word_cnt <= '0;
							state    <= S_CRC;
						end else begin
							word_cnt <= word_cnt + 1'b1;
						end
					end
				end
				// the crc sits in the first pair after the payload
				S_CRC: begin
					if (lane0_valid) begin
						push_o <= 1'b1;
						state  <= S_IGNORE;
					end
				end
				default: begin
				end
			endcase
		end
	end

	// entry contents follow the state and count only with push_o
	always_ff @(posedge mipi_clk_2) begin
		if (lane0_valid && !pair_sel) begin
			low_half <= {lane1_byte, lane0_byte};
		end
		case (state)
			S_HDR: begin
				push_data_o <= '0;
				push_tag_o  <= csi2_pkg::TAG_FS;
			end
			S_PAYLOAD: begin
				push_data_o <= word;
				push_tag_o  <= csi2_pkg::TAG_DATA;
			end
			default: begin
				push_data_o <= {16'h0000, lane1_byte, lane0_byte};
				push_tag_o  <= csi2_pkg::TAG_CRC;
			end
		endcase
	end

endmodule

// File: hw/payload_fifo.sv
module payload_fifo (
	input  logic                        mipi_clk_2,
	input  logic                        reset,
	input  logic                        push_i,
	input  logic [csi2_pkg::WORD_W-1:0] push_data_i,
	input  logic [csi2_pkg::TAG_W-1:0]  push_tag_i,
	input  logic                        pop_i,
	output logic [csi2_pkg::WORD_W-1:0] pop_data_o,
	output logic [csi2_pkg::TAG_W-1:0]  pop_tag_o,
	output logic                        empty_o,
	output logic                        fifo_overflow_o
);

	// tag in the top bits, data word below
	logic [csi2_pkg::TAG_W+csi2_pkg::WORD_W-1:0] mem [csi2_pkg::FIFO_DEPTH];

	logic [$clog2(csi2_pkg::FIFO_DEPTH)-1:0]   wr_ptr;
	logic [$clog2(csi2_pkg::FIFO_DEPTH)-1:0]   rd_ptr;
	logic [$clog2(csi2_pkg::FIFO_DEPTH+1)-1:0] fill_count;
	logic                                      full;
	logic                                      wr_en;
	logic                                      rd_en;

	assign full    = fill_count == ($bits(fill_count))'(csi2_pkg::FIFO_DEPTH);
	assign empty_o = fill_count == '0;
	assign wr_en   = push_i && !full;
	assign rd_en   = pop_i && !empty_o;

	// first-word fall-through, head entry always on the outputs
	assign {pop_tag_o, pop_data_o} = mem[rd_ptr];

	always_ff @(posedge mipi_clk_2) begin
		if (wr_en) begin
			mem[wr_ptr] <= {push_tag_i, push_data_i};
		end
	end

	// pointers wrap on their own, depth is a power of two
	always_ff @(posedge mipi_clk_2) begin
		if (reset) begin
			wr_ptr          <= '0;
			rd_ptr          <= '0;
			fill_count      <= '0;
			fifo_overflow_o <= 1'b0;
		end else begin
			if (wr_en) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (rd_en) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			if (wr_en && !rd_en) begin
				fill_count <= fill_count + 1'b1;
			end else if (rd_en && !wr_en) begin
				fill_count <= fill_count - 1'b1;
			end
			// sticky, the dropped entry is lost
			if (push_i && full) begin
				fifo_overflow_o <= 1'b1;
			end
		end
	end

endmodule

// File: hw/frame_writer.sv
module frame_writer (
	input  logic                        mipi_clk_2,
	input  logic                        reset,
	input  logic                        empty_i,
	input  logic [csi2_pkg::WORD_W-1:0] pop_data_i,
	input  logic [csi2_pkg::TAG_W-1:0]  pop_tag_i,
	output logic                        pop_o,
	output logic                        ram_we_o,
	output logic [31:0]                 ram_addr_o,
	output logic [csi2_pkg::WORD_W-1:0] ram_data_o,
	output logic [15:0]                 line_count_o,
	output logic                        line_done_o,
	output logic                        crc_ok_o
);

	logic [15:0] crc;
	logic [31:0] next_addr;

	////////////////////////////////////////////////////////////
	// CRC-16 over bytes least significant first and bits lsb first
	////////////////////////////////////////////////////////////

	function automatic logic [15:0] crc_fold_word(
		input logic [15:0]                 crc_in,
		input logic [csi2_pkg::WORD_W-1:0] data
	);
		logic [15:0] c;
		logic        fb;
		c = crc_in;
		for (int i = 0; i < csi2_pkg::WORD_W; i++) begin
			fb = c[0] ^ data[i];
			c  = c >> 1;
			if (fb) begin
				c = c ^ csi2_pkg::CRC_POLY;
			end
		end
		return c;
	endfunction

	// fifo output is valid while not empty, so take one entry per cycle
	assign pop_o = !empty_i;

	////////////////////////////////////////////////////////////
	// entry handling
	////////////////////////////////////////////////////////////

	always_ff @(posedge mipi_clk_2) begin
		if (reset) begin
			ram_we_o     <= 1'b0;
			ram_addr_o   <= '0;
			next_addr    <= '0;
			line_count_o <= '0;
			line_done_o  <= 1'b0;
			crc_ok_o     <= 1'b0;
			crc          <= csi2_pkg::CRC_INIT;
		end else begin
			ram_we_o    <= 1'b0;
			line_done_o <= 1'b0;
			if (pop_o) begin
				case (pop_tag_i)
					csi2_pkg::TAG_FS: begin
						ram_addr_o   <= '0;
						next_addr    <= '0;
						line_count_o <= '0;
						crc          <= csi2_pkg::CRC_INIT;
					end
					csi2_pkg::TAG_DATA: begin
						ram_we_o   <= 1'b1;
						ram_addr_o <= next_addr;
						next_addr  <= next_addr + 1'b1;
						crc        <= crc_fold_word(crc, pop_data_i);
					end
					csi2_pkg::TAG_CRC: begin
						line_done_o  <= 1'b1;
						// holds its value until the next line ends
						crc_ok_o     <= pop_data_i[15:0] == crc;
						line_count_o <= line_count_o + 1'b1;
						crc          <= csi2_pkg::CRC_INIT;
					end
					default: begin
					end
				endcase
			end
		end
	end

	// write data register loaded from each data entry
	always_ff @(posedge mipi_clk_2) begin
		if (pop_o && (pop_tag_i == csi2_pkg::TAG_DATA)) begin
			ram_data_o <= pop_data_i;
		end
	end

endmodule

// File: hw/csi2_rx_top.sv
module csi2_rx_top (
	input  logic                          mipi_clk_2,
	input  logic                          reset,
	input  logic                          rx_active_i,
	input  logic [csi2_pkg::NIBBLE_W-1:0] lane0_bits_i,
	input  logic [csi2_pkg::NIBBLE_W-1:0] lane1_bits_i,
	output logic                          ram_we_o,
	output logic [31:0]                   ram_addr_o,
	output logic [csi2_pkg::WORD_W-1:0]   ram_data_o,
	output logic [15:0]                   line_count_o,
	output logic                          line_done_o,
	output logic                          crc_ok_o,
	output logic                          fifo_overflow_o
);

	// parser to buffer
	logic                        push;
	logic [csi2_pkg::WORD_W-1:0] push_data;
	logic [csi2_pkg::TAG_W-1:0]  push_tag;

	// buffer to writer
	logic                        pop;
	logic [csi2_pkg::WORD_W-1:0] pop_data;
	logic [csi2_pkg::TAG_W-1:0]  pop_tag;
	logic                        empty;

	csi_packet_parser u_parser (
		.mipi_clk_2   (mipi_clk_2),
		.reset        (reset),
		.rx_active_i  (rx_active_i),
		.lane0_bits_i (lane0_bits_i),
		.lane1_bits_i (lane1_bits_i),
		.push_o       (push),
		.push_data_o  (push_data),
		.push_tag_o   (push_tag)
	);

	payload_fifo u_fifo (
		.mipi_clk_2      (mipi_clk_2),
		.reset           (reset),
		.push_i          (push),
		.push_data_i     (push_data),
		.push_tag_i      (push_tag),
		.pop_i           (pop),
		.pop_data_o      (pop_data),
		.pop_tag_o       (pop_tag),
		.empty_o         (empty),
		.fifo_overflow_o (fifo_overflow_o)
	);

	frame_writer u_writer (
		.mipi_clk_2   (mipi_clk_2),
		.reset        (reset),
		.empty_i      (empty),
		.pop_data_i   (pop_data),
		.pop_tag_i    (pop_tag),
		.pop_o        (pop),
		.ram_we_o     (ram_we_o),
		.ram_addr_o   (ram_addr_o),
		.ram_data_o   (ram_data_o),
		.line_count_o (line_count_o),
		.line_done_o  (line_done_o),
		.crc_ok_o     (crc_ok_o)
	);

endmodule

// File: testbench/csi2_rx_assertions.sv
module csi2_rx_assertions (
	input logic                                          mipi_clk_2,
	input logic                                          reset,
	input logic                                          pop_i,
	input logic                                          empty_i,
	input logic [$clog2(csi2_pkg::FIFO_DEPTH+1)-1:0]     fill_count_i,
	input logic                                          fifo_overflow_i
);

	// the writer may only take an entry that is there
	no_pop_when_empty: assert property (@(posedge mipi_clk_2) disable iff (reset)
		pop_i |-> !empty_i)
		else $error("FIFO popped while empty");

	fill_in_range: assert property (@(posedge mipi_clk_2) disable iff (reset)
		fill_count_i <= ($bits(fill_count_i))'(csi2_pkg::FIFO_DEPTH))
		else $error("FIFO occupancy above its depth");

	// overflow flag starts out clear
	overflow_clear_after_reset: assert property (@(posedge mipi_clk_2)
		reset |=> !fifo_overflow_i)
		else $error("FIFO overflow flag set right after reset");

endmodule

bind payload_fifo csi2_rx_assertions u_fifo_checks (
	.mipi_clk_2      (mipi_clk_2),
	.reset           (reset),
	.pop_i           (pop_i),
	.empty_i         (empty_o),
	.fill_count_i    (fill_count),
	.fifo_overflow_i (fifo_overflow_o)
);

// File: testbench/csi2_rx_tb.sv
module csi2_rx_tb;

	// column i is the CSI-2 header ECC of bit i alone
	localparam logic [191:0] ECC_COLS =
		192'h3B372F1F_38343231_2C2A2926_25231C1A_19161513_0E0D0B07;

	logic        mipi_clk_2;
	logic        reset;
	logic        rx_active_i;
	logic [3:0]  lane0_bits_i;
	logic [3:0]  lane1_bits_i;
	logic        ram_we_o;
	logic [31:0] ram_addr_o;
	logic [31:0] ram_data_o;
	logic [15:0] line_count_o;
	logic        line_done_o;
	logic        crc_ok_o;
	logic        fifo_overflow_o;

	int          error_count;
	logic [15:0] lfsr;
	logic [31:0] sent_words[$];
	logic [31:0] first_line[$];
	logic [31:0] wr_addr_q[$];
	logic [31:0] wr_data_q[$];
	logic        done_ok_q[$];
	logic [15:0] done_cnt_q[$];

	csi2_rx_top u_csi2_rx_top (
		.mipi_clk_2      (mipi_clk_2),
		.reset           (reset),
		.rx_active_i     (rx_active_i),
		.lane0_bits_i    (lane0_bits_i),
		.lane1_bits_i    (lane1_bits_i),
		.ram_we_o        (ram_we_o),
		.ram_addr_o      (ram_addr_o),
		.ram_data_o      (ram_data_o),
		.line_count_o    (line_count_o),
		.line_done_o     (line_done_o),
		.crc_ok_o        (crc_ok_o),
		.fifo_overflow_o (fifo_overflow_o)
	);

	initial begin
		mipi_clk_2 = 1'b0;
		forever #4 mipi_clk_2 = ~mipi_clk_2;
	end

	// ram writes and line ends are sampled mid-cycle
	always @(negedge mipi_clk_2) begin
		if (!reset) begin
			if (ram_we_o) begin
				wr_addr_q.push_back(ram_addr_o);
				wr_data_q.push_back(ram_data_o);
			end
			if (line_done_o) begin
				done_ok_q.push_back(crc_ok_o);
				done_cnt_q.push_back(line_count_o);
			end
		end
	end

	////////////////////////////////////////////////////////////
	// reference models
	////////////////////////////////////////////////////////////

	// galois form of x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	task automatic draw_byte(output logic [7:0] b);
		for (int i = 0; i < 8; i++) begin
			b[i] = lfsr[0];
			lfsr = lfsr_step(lfsr);
		end
	endtask

	function automatic logic [7:0] header_ecc(input logic [23:0] d);
		logic [7:0] e;
		e = '0;
		for (int i = 0; i < 24; i++) begin
			if (d[i]) begin
				e = e ^ ECC_COLS[i*8 +: 8];
			end
		end
		return e;
	endfunction

	function automatic logic [15:0] crc16_byte(input logic [15:0] c, input logic [7:0] b);
		logic [15:0] r;
		r = c;
		for (int i = 0; i < 8; i++) begin
			if (r[0] ^ b[i]) begin
				r = (r >> 1) ^ 16'h8408;
			end else begin
				r = r >> 1;
			end
		end
		return r;
	endfunction

	task automatic make_payload(input int nbytes);
		logic [7:0]  b;
		logic [31:0] w;
		sent_words.delete();
		for (int i = 0; i < nbytes; i++) begin
			draw_byte(b);
			w[8*(i%4) +: 8] = b;
			if (i % 4 == 3) begin
				sent_words.push_back(w);
			end
		end
	endtask

	////////////////////////////////////////////////////////////
	// lane serializer
	////////////////////////////////////////////////////////////

	// sync byte on both lanes and then even bytes on lane 0 and odd bytes on lane 1
	task automatic send_burst(input logic [7:0] bytes[$], input bit uneven);
		logic       bits0[$];
		logic       bits1[$];
		logic [7:0] b;
		int         n;
		if (uneven) begin
			repeat (2) begin
				bits0.push_back(1'b0);
				bits1.push_back(1'b0);
			end
		end
		for (int i = 0; i < 8; i++) begin
			bits0.push_back(csi2_pkg::SYNC_BYTE[i]);
			bits1.push_back(csi2_pkg::SYNC_BYTE[i]);
		end
		for (int k = 0; k < bytes.size(); k++) begin
			b = bytes[k];
			for (int i = 0; i < 8; i++) begin
				if (k % 2 == 0) begin
					bits0.push_back(b[i]);
				end else begin
					bits1.push_back(b[i]);
				end
			end
		end
		// idle bits flush the last pair through the aligners
		while (bits0.size() < bytes.size() * 4 + 32 || bits0.size() % 4 != 0) begin
			bits0.push_back(1'b0);
			bits1.push_back(1'b0);
		end
		n = bits0.size() / 4;
		for (int k = 0; k < n; k++) begin
			@(negedge mipi_clk_2);
			rx_active_i = 1'b1;
			for (int i = 0; i < 4; i++) begin
				lane0_bits_i[i] = bits0[4*k+i];
				lane1_bits_i[i] = bits1[4*k+i];
			end
		end
		@(negedge mipi_clk_2);
		rx_active_i  = 1'b0;
		lane0_bits_i = '0;
		lane1_bits_i = '0;
		repeat (3) @(negedge mipi_clk_2);
	endtask

	// long packets carry sent_words and their CRC
	task automatic send_packet(input logic [5:0] dt, input logic [15:0] wc,
			input logic [23:0] flip, input bit long_pkt, input bit bad_crc, input bit uneven);
		logic [23:0] hdr;
		logic [7:0]  ecc;
		logic [7:0]  bytes[$];
		logic [15:0] crc;
		logic [31:0] w;
		hdr = {wc, 2'b00, dt};
		ecc = header_ecc(hdr);
		hdr = hdr ^ flip;
		bytes.push_back(hdr[7:0]);
		bytes.push_back(hdr[15:8]);
		bytes.push_back(hdr[23:16]);
		bytes.push_back(ecc);
		if (long_pkt) begin
			crc = 16'hFFFF;
			foreach (sent_words[k]) begin
				w = sent_words[k];
				for (int i = 0; i < 4; i++) begin
					bytes.push_back(w[8*i +: 8]);
					crc = crc16_byte(crc, w[8*i +: 8]);
				end
			end
			if (bad_crc) begin
				crc = crc ^ 16'h0100;
			end
			bytes.push_back(crc[7:0]);
			bytes.push_back(crc[15:8]);
		end
		send_burst(bytes, uneven);
	endtask

	////////////////////////////////////////////////////////////
	// checking
	////////////////////////////////////////////////////////////

	task automatic wait_for_output(input int n_writes, input int n_lines);
		int cycles;
		cycles = 0;
		while ((wr_addr_q.size() < n_writes || done_ok_q.size() < n_lines) && cycles < 2000) begin
			@(negedge mipi_clk_2);
			cycles++;
		end
		if (cycles >= 2000) begin
			error_count++;
			$display("timeout: expected RAM writes or line end never arrived");
		end
	endtask

	task automatic clear_capture();
		wr_addr_q.delete();
		wr_data_q.delete();
		done_ok_q.delete();
		done_cnt_q.delete();
	endtask

	task automatic check_line(input int base, input int count, input bit crc_good);
		wait_for_output(csi2_pkg::LINE_WORDS, 1);
		assert (wr_addr_q.size() == csi2_pkg::LINE_WORDS) else begin
			error_count++;
			$display("** Error at %0t: %0d RAM writes, expected %0d", $time,
				wr_addr_q.size(), csi2_pkg::LINE_WORDS);
		end
		for (int i = 0; i < wr_addr_q.size() && i < sent_words.size(); i++) begin
			assert (wr_addr_q[i] == 32'(base + i) && wr_data_q[i] == sent_words[i]) else begin
				error_count++;
				$display("** Error at %0t: write %0d at %0d data %h, expected %0d data %h",
					$time, i, wr_addr_q[i], wr_data_q[i], base + i, sent_words[i]);
			end
		end
		if (done_ok_q.size() > 0) begin
			assert (done_ok_q[0] == crc_good && done_cnt_q[0] == 16'(count)) else begin
				error_count++;
				$display("** Error at %0t: line end crc_ok %0b count %0d, expected %0b and %0d",
					$time, done_ok_q[0], done_cnt_q[0], crc_good, count);
			end
		end
		clear_capture();
	endtask

	////////////////////////////////////////////////////////////
	// directed tests
	////////////////////////////////////////////////////////////

	task automatic test_first_line();
		send_packet(csi2_pkg::DT_FRAME_START, 16'd1, '0, 1'b0, 1'b0, 1'b0);
		make_payload(csi2_pkg::LINE_BYTES);
		first_line = sent_words;
		send_packet(csi2_pkg::DT_RAW8, 16'(csi2_pkg::LINE_BYTES), '0, 1'b1, 1'b0, 1'b0);
		check_line(0, 1, 1'b1);
	endtask

	task automatic test_second_line();
		int cycles;
		make_payload(csi2_pkg::LINE_BYTES);
		send_packet(csi2_pkg::DT_RAW8, 16'(csi2_pkg::LINE_BYTES), '0, 1'b1, 1'b0, 1'b0);
		check_line(csi2_pkg::LINE_WORDS, 2, 1'b1);
		send_packet(csi2_pkg::DT_FRAME_START, 16'd2, '0, 1'b0, 1'b0, 1'b0);
		cycles = 0;
		while (line_count_o != 16'd0 && cycles < 200) begin
			@(negedge mipi_clk_2);
			cycles++;
		end
		assert (line_count_o == 16'd0) else begin
			error_count++;
			$display("** Error at %0t: line count %0d after frame start, expected 0",
				$time, line_count_o);
		end
	endtask

	// address restart after the frame start is checked here too
	task automatic test_bad_crc();
		make_payload(csi2_pkg::LINE_BYTES);
		send_packet(csi2_pkg::DT_RAW8, 16'(csi2_pkg::LINE_BYTES), '0, 1'b1, 1'b1, 1'b0);
		check_line(0, 1, 1'b0);
	endtask

	task automatic test_header_errors();
		send_packet(csi2_pkg::DT_FRAME_START, 16'd3, '0, 1'b0, 1'b0, 1'b0);
		make_payload(csi2_pkg::LINE_BYTES);
		send_packet(csi2_pkg::DT_RAW8, 16'(csi2_pkg::LINE_BYTES), 24'h000008, 1'b1, 1'b0, 1'b0);
		check_line(0, 1, 1'b1);
		// none of these may reach the RAM
		make_payload(csi2_pkg::LINE_BYTES);
		// two flips in the virtual channel bits leave type and length intact
		send_packet(csi2_pkg::DT_RAW8, 16'(csi2_pkg::LINE_BYTES), 24'h0000C0, 1'b1, 1'b0, 1'b0);
		send_packet(6'h2B, 16'(csi2_pkg::LINE_BYTES), '0, 1'b1, 1'b0, 1'b0);
		make_payload(csi2_pkg::LINE_BYTES / 2);
		send_packet(csi2_pkg::DT_RAW8, 16'(csi2_pkg::LINE_BYTES / 2), '0, 1'b1, 1'b0, 1'b0);
		for (int i = 0; i < 100; i++) begin
			@(negedge mipi_clk_2);
		end
		assert (wr_addr_q.size() == 0 && done_ok_q.size() == 0 && line_count_o == 16'd1) else begin
			error_count++;
			$display("** Error at %0t: %0d writes, %0d line ends, line count %0d after rejects",
				$time, wr_addr_q.size(), done_ok_q.size(), line_count_o);
		end
		clear_capture();
	endtask

	task automatic test_uneven_phase();
		send_packet(csi2_pkg::DT_FRAME_START, 16'd4, '0, 1'b0, 1'b0, 1'b1);
		sent_words = first_line;
		send_packet(csi2_pkg::DT_RAW8, 16'(csi2_pkg::LINE_BYTES), '0, 1'b1, 1'b0, 1'b1);
		check_line(0, 1, 1'b1);
	endtask

	initial begin
		error_count  = 0;
		lfsr         = 16'd63128;
		reset        = 1'b1;
		rx_active_i  = 1'b0;
		lane0_bits_i = '0;
		lane1_bits_i = '0;
		repeat (10) @(negedge mipi_clk_2);
		reset = 1'b0;
		repeat (2) @(negedge mipi_clk_2);

		test_first_line();
		test_second_line();
		test_bad_crc();
		test_header_errors();
		test_uneven_phase();

		assert (!fifo_overflow_o) else begin
			error_count++;
			$display("** Error at %0t: FIFO overflow flag set", $time);
		end
		$display("checks finished with %0d errors", error_count);
		if (error_count == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

// File: sim.f
hw/csi2_pkg.sv
hw/hs_lane_aligner.sv
hw/csi_packet_parser.sv
hw/payload_fifo.sv
hw/frame_writer.sv
hw/csi2_rx_top.sv
testbench/csi2_rx_assertions.sv
testbench/csi2_rx_tb.sv
